// ==== merge_cfg_pkg.sv ====
package merge_cfg_pkg;

  // Structural constants of the merger
  localparam int num_ports  = 8;
  localparam int port_idx_w = 3;

  // Width of the request word used by the shared data types
  localparam int default_data_width = 32;

  // Free slots kept in reserve once a FIFO reports almost full
  localparam int fifo_af_margin = 6;

  // Almost-empty levels, flag is set at or below the level
  localparam int in_ae_level  = 4;
  localparam int out_ae_level = 2;

  // Number of entries for a FIFO of the given address width
  function automatic int fifo_depth(input int depth_bits);
    return 1 << depth_bits;
  endfunction

  // Almost full is raised once count reaches depth minus the margin
  function automatic int fifo_af_level(input int depth_bits);
    return fifo_depth(depth_bits) - fifo_af_margin;
  endfunction

endpackage

// ==== req_types_pkg.sv ====
package req_types_pkg;

  // One bit per port, for requests, grants, read strobes and available flags
  typedef logic [merge_cfg_pkg::num_ports-1:0] port_mask_t;

  // Encoded port number
  typedef logic [merge_cfg_pkg::port_idx_w-1:0] port_idx_t;

  // One request word at the default width
  typedef logic [merge_cfg_pkg::default_data_width-1:0] req_word_t;

  typedef struct packed {
    logic      valid;
    req_word_t word;
  } req_beat_t;

  typedef struct packed {
    logic       valid;
    port_mask_t mask;
    port_idx_t  idx;
  } arb_grant_t;

endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int width      = 32,
  parameter int depth_bits = 4,
  parameter int af_level   = 10,
  parameter int ae_level   = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic [width-1:0]      wr_data,
  input  logic                  rd_en,
  output logic                  rd_valid,
  output logic [width-1:0]      rd_data,
  output logic [depth_bits:0]   count,
  output logic                  empty,
  output logic                  full,
  output logic                  almost_full,
  output logic                  almost_empty
);

  localparam int depth = 1 << depth_bits;
  localparam logic [depth_bits:0] full_cnt = (depth_bits + 1)'(depth);
  localparam logic [depth_bits:0] af_cnt   = (depth_bits + 1)'(af_level);
  localparam logic [depth_bits:0] ae_cnt   = (depth_bits + 1)'(ae_level);

  logic [width-1:0]      mem [depth];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign empty        = (count == '0);
  assign full         = (count == full_cnt);
  assign almost_full  = (count >= af_cnt);
  assign almost_empty = (count <= ae_cnt);

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
    if (do_rd) begin
      rd_data <= mem[rd_ptr]; // Data lines up with rd_valid one cycle after the read
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_rd;
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The writer must respect the almost-full margin and never fill the last slot over
  assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full));

  // The reader paces itself from delayed flags and must never reach past empty
  assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty));

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  req_types_pkg::port_mask_t request,
  output req_types_pkg::arb_grant_t grant
);

  import merge_cfg_pkg::*;
  import req_types_pkg::*;

  port_idx_t ptr; // Highest priority port for the current cycle

  // First requester at or after the pointer wins
  always_comb begin
    port_idx_t cand;
    grant = '0;
    for (int i = 0; i < num_ports; i++) begin
      cand = port_idx_t'(ptr + i); // Wraps around the port count
      if (request[cand] && !grant.valid) begin
        grant.valid     = 1'b1;
        grant.mask[cand] = 1'b1;
        grant.idx       = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (grant.valid) begin
      ptr <= grant.idx + 1'b1; // Winner drops to lowest priority
    end
  end

  // A grant goes to exactly one port, and only to one that asked
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant.mask) && ((grant.mask & ~request) == '0));

endmodule

// ==== req_select.sv ====
`timescale 1ns/1ps

module req_select #(
  parameter int data_width = 32
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  req_types_pkg::port_mask_t                            in_valid,
  input  logic [merge_cfg_pkg::num_ports-1:0][data_width-1:0] in_data,
  output req_types_pkg::req_beat_t                             beat
);

  import merge_cfg_pkg::*;
  import req_types_pkg::*;

  logic [data_width-1:0] sel_word;

  // At most one lane is valid, so an AND-OR mux is enough
  always_comb begin
    sel_word = '0;
    for (int i = 0; i < num_ports; i++) begin
      sel_word = sel_word | (in_data[i] & {data_width{in_valid[i]}});
    end
  end

  always_ff @(posedge clk) begin
    beat.word <= sel_word;
    if (!rst_n) begin
      beat.valid <= 1'b0;
    end else begin
      beat.valid <= |in_valid; // Doubles as the output FIFO write strobe
    end
  end

  // The controller strobes a single input FIFO per cycle, so only one answers
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(in_valid));

endmodule

// ==== rd_req_arb_ctrl.sv ====
`timescale 1ns/1ps

module rd_req_arb_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  req_types_pkg::port_mask_t in_empty,
  input  req_types_pkg::port_mask_t in_almost_empty,
  input  req_types_pkg::port_mask_t in_almost_full,
  input  logic                      out_empty,
  input  logic                      out_almost_empty,
  input  logic                      out_almost_full,
  input  logic                      req_avail_out,
  output req_types_pkg::port_mask_t in_rd_en,
  output logic                      out_rd_en,
  output req_types_pkg::port_mask_t req_avail_in
);

  import merge_cfg_pkg::*;
  import req_types_pkg::*;

  port_mask_t fast_req;
  port_mask_t slow_req;
  arb_grant_t fast_grant;
  arb_grant_t slow_grant;
  logic [1:0] hold_cnt;
  logic       slow_take;

  // Fast side streams from FIFOs with some depth, slow side drains the last words
  assign fast_req = ~in_almost_empty & {num_ports{~out_almost_full}};
  assign slow_req = ~in_empty & {num_ports{~out_almost_full}};

  rr_arbiter fast_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .request (fast_req),
    .grant   (fast_grant)
  );

  rr_arbiter slow_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .request (slow_req),
    .grant   (slow_grant)
  );

  // A slow read must land before the next slow grant can look at the counts
  assign slow_take = !fast_grant.valid && slow_grant.valid && (hold_cnt == 2'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_rd_en <= '0;
      hold_cnt <= 2'd0;
    end else begin
      if (fast_grant.valid) begin
        in_rd_en <= fast_grant.mask; // Fast grant always wins
      end else if (slow_take) begin
        in_rd_en <= slow_grant.mask;
      end else begin
        in_rd_en <= '0;
      end
      if (slow_take) begin
        hold_cnt <= 2'd2; // Blocks slow grants for the next two cycles
      end else if (hold_cnt != 2'd0) begin
        hold_cnt <= hold_cnt - 2'd1;
      end
    end
  end

  // Near empty, reads go out every other cycle so the registered strobe never
  // overruns the last entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_rd_en <= 1'b0;
    end else if (out_almost_empty) begin
      out_rd_en <= req_avail_out && !out_empty && !out_rd_en;
    end else begin
      out_rd_en <= req_avail_out;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_avail_in <= '0;
    end else begin
      req_avail_in <= ~in_almost_full; // Margin covers the words still in flight
    end
  end

  // The grant rules and hold counter keep every strobe on a FIFO with data left
  assert property (@(posedge clk) disable iff (!rst_n) (in_rd_en & in_empty) == '0);

endmodule

// ==== rd_req_merge.sv ====
`timescale 1ns/1ps

module rd_req_merge #(
  parameter int data_width     = 32,
  parameter int in_depth_bits  = 4,
  parameter int out_depth_bits = 4
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  req_types_pkg::port_mask_t                            req_wr_en_in,
  input  logic [merge_cfg_pkg::num_ports-1:0][data_width-1:0] req_wr_data_in,
  output req_types_pkg::port_mask_t                            req_avail_in,
  input  logic                                                 req_avail_out,
  output logic                                                 req_wr_en_out,
  output logic [data_width-1:0]                                req_wr_data_out
);

  import merge_cfg_pkg::*;
  import req_types_pkg::*;

  port_mask_t                            in_wr_en;
  logic [num_ports-1:0][data_width-1:0] in_wr_data;
  port_mask_t                            in_rd_en;
  port_mask_t                            in_valid;
  logic [num_ports-1:0][data_width-1:0] in_rd_data;
  port_mask_t                            in_empty;
  port_mask_t                            in_almost_empty;
  port_mask_t                            in_almost_full;
  req_beat_t                             sel_beat;
  req_beat_t                             out_beat;
  logic                                  out_rd_en;
  logic                                  out_empty;
  logic                                  out_almost_empty;
  logic                                  out_almost_full;

  // Input strobes are registered once before they reach the FIFOs
  always_ff @(posedge clk) begin
    in_wr_data <= req_wr_data_in;
    if (!rst_n) begin
      in_wr_en <= '0;
    end else begin
      in_wr_en <= req_wr_en_in;
    end
  end

  for (genvar i = 0; i < num_ports; i++) begin : g_in_fifo
    sync_fifo #(
      .width      (data_width),
      .depth_bits (in_depth_bits),
      .af_level   (fifo_af_level(in_depth_bits)),
      .ae_level   (in_ae_level)
    ) in_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr_en        (in_wr_en[i]),
      .wr_data      (in_wr_data[i]),
      .rd_en        (in_rd_en[i]),
      .rd_valid     (in_valid[i]),
      .rd_data      (in_rd_data[i]),
      .count        (),
      .empty        (in_empty[i]),
      .full         (),
      .almost_full  (in_almost_full[i]),
      .almost_empty (in_almost_empty[i])
    );
  end

  rd_req_arb_ctrl ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_empty         (in_empty),
    .in_almost_empty  (in_almost_empty),
    .in_almost_full   (in_almost_full),
    .out_empty        (out_empty),
    .out_almost_empty (out_almost_empty),
    .out_almost_full  (out_almost_full),
    .req_avail_out    (req_avail_out),
    .in_rd_en         (in_rd_en),
    .out_rd_en        (out_rd_en),
    .req_avail_in     (req_avail_in)
  );

  req_select #(
    .data_width (data_width)
  ) select (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_data  (in_rd_data),
    .beat     (sel_beat)
  );

  sync_fifo #(
    .width      (data_width),
    .depth_bits (out_depth_bits),
    .af_level   (fifo_af_level(out_depth_bits)),
    .ae_level   (out_ae_level)
  ) out_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (sel_beat.valid),
    .wr_data      (sel_beat.word),
    .rd_en        (out_rd_en),
    .rd_valid     (out_beat.valid),
    .rd_data      (out_beat.word),
    .count        (),
    .empty        (out_empty),
    .full         (),
    .almost_full  (out_almost_full),
    .almost_empty (out_almost_empty)
  );

  always_ff @(posedge clk) begin
    req_wr_data_out <= out_beat.word;
    if (!rst_n) begin
      req_wr_en_out <= 1'b0;
    end else begin
      req_wr_en_out <= out_beat.valid;
    end
  end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1; // Released on a falling edge like the rest of the stimulus
  end

endmodule

// ==== tb_rd_req_checks.svh ====
// Request word layout, port number on top and sequence number below
function automatic req_word_t seq_word(input port_idx_t port, input int seq);
  logic [default_data_width-port_idx_w-1:0] seq_bits;
  seq_bits = seq[default_data_width-port_idx_w-1:0];
  return {port, seq_bits};
endfunction

// Next word the given port must deliver, from the count already seen
function automatic req_word_t expected_next(input port_idx_t port);
  return seq_word(port, rcv_cnt[port]);
endfunction

task automatic check_word(
  input string     name,
  input req_word_t got,
  input req_word_t exp
);
  if (got !== exp) begin
    abort_run($sformatf("ERROR t=%0t %s got 0x%08h expected 0x%08h",
                        $time, name, got, exp));
  end
endtask

task automatic check_mask(
  input string      name,
  input port_mask_t got,
  input port_mask_t exp
);
  if (got !== exp) begin
    abort_run($sformatf("ERROR t=%0t %s got 0x%02h expected 0x%02h",
                        $time, name, got, exp));
  end
endtask

// ==== tb_rd_req_merge.sv ====
`timescale 1ns/1ps

module tb_rd_req_merge;

  import merge_cfg_pkg::*;
  import req_types_pkg::*;

  localparam int data_width       = default_data_width;
  localparam int words_single     = 200;
  localparam int words_all_each   = 120;
  localparam int flow_words_max   = 40;
  localparam int flow_hold_cycles = 80;
  localparam int flow_port        = 5;
  localparam int words_bp_each    = 40;
  localparam int late_limit       = 3;
  localparam int total_words      = words_single + num_ports * words_all_each
                                    + flow_words_max + num_ports * words_bp_each;
  localparam int watchdog_cycles  = 40 * total_words + 1000;

  logic                                 clk;
  logic                                 rst_n;
  port_mask_t                           req_wr_en_in;
  logic [num_ports-1:0][data_width-1:0] req_wr_data_in;
  port_mask_t                           req_avail_in;
  logic                                 req_avail_out;
  logic                                 req_wr_en_out;
  logic [data_width-1:0]                req_wr_data_out;

  int   sent_cnt [num_ports];
  int   rcv_cnt  [num_ports];
  logic traffic_done;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  `include "tb_rd_req_checks.svh"

  tb_clk_gen #(
    .period_ns    (4),
    .reset_cycles (4)
  ) clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rd_req_merge #(
    .data_width     (data_width),
    .in_depth_bits  (4),
    .out_depth_bits (4)
  ) DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_wr_en_in    (req_wr_en_in),
    .req_wr_data_in  (req_wr_data_in),
    .req_avail_in    (req_avail_in),
    .req_avail_out   (req_avail_out),
    .req_wr_en_out   (req_wr_en_out),
    .req_wr_data_out (req_wr_data_out)
  );

  // Every delivered word must be the next one that its port sent
  always @(negedge clk) begin : scoreboard
    port_idx_t src;
    if (rst_n && req_wr_en_out) begin
      src = req_wr_data_out[data_width-1 -: port_idx_w];
      if (rcv_cnt[src] >= sent_cnt[src]) begin
        abort_run($sformatf("Port %0d delivered a word at %0t that was never sent",
                            src, $time));
      end
      check_word("req_wr_data_out", req_wr_data_out, expected_next(src));
      rcv_cnt[src]++;
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("Timeout after %0d cycles, traffic never drained", watchdog_cycles));
  end

  // Called at a falling edge, writes on every wanted port whose flag is up
  task automatic drive_cycle(input port_mask_t want);
    for (int i = 0; i < num_ports; i++) begin
      if (want[i] && req_avail_in[i]) begin
        req_wr_en_in[i]   = 1'b1;
        req_wr_data_in[i] = seq_word(port_idx_t'(i), sent_cnt[i]);
        sent_cnt[i]++;
      end else begin
        req_wr_en_in[i]   = 1'b0;
        req_wr_data_in[i] = '0;
      end
    end
  endtask

  task automatic run_traffic(input port_mask_t ports, input int words_each);
    int         target [num_ports];
    int         rate   [num_ports];
    port_mask_t want;
    logic       busy;
    for (int i = 0; i < num_ports; i++) begin
      target[i] = sent_cnt[i] + (ports[i] ? words_each : 0);
      rate[i]   = 20 + int'($urandom_range(70)); // Percent chance of a write per cycle
    end
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int i = 0; i < num_ports; i++) begin
        want[i] = (sent_cnt[i] < target[i]) && (int'($urandom_range(99)) < rate[i]);
      end
      drive_cycle(want);
      for (int i = 0; i < num_ports; i++) begin
        if (sent_cnt[i] < target[i]) busy = 1'b1;
      end
    end
    @(negedge clk);
    req_wr_en_in = '0;
  endtask

  task automatic wait_drained();
    logic pending;
    pending = 1'b1;
    while (pending) begin
      @(negedge clk);
      pending = 1'b0;
      for (int i = 0; i < num_ports; i++) begin
        if (rcv_cnt[i] != sent_cnt[i]) pending = 1'b1;
      end
    end
  endtask

  // Consumer that drops its flag at random and counts the words that trail in
  task automatic toggle_consumer();
    int late;
    while (!traffic_done) begin
      req_avail_out = 1'b1;
      repeat ($urandom_range(20, 5)) @(negedge clk);
      req_avail_out = 1'b0;
      late = 0;
      repeat ($urandom_range(20, 5)) begin
        @(negedge clk);
        if (req_wr_en_out) late++;
      end
      if (late > late_limit) begin
        abort_run($sformatf("At %0t, %0d words arrived after req_avail_out fell, limit is %0d",
                            $time, late, late_limit));
      end
    end
    req_avail_out = 1'b1;
  endtask

  initial begin : stimulus
    port_mask_t flow_bit;
    int         base [num_ports];
    void'($urandom(32'he6ca));
    req_wr_en_in        = '0;
    req_wr_data_in      = '0;
    req_avail_out       = 1'b1;
    traffic_done        = 1'b0;
    flow_bit            = '0;
    flow_bit[flow_port] = 1'b1;
    for (int i = 0; i < num_ports; i++) begin
      sent_cnt[i] = 0;
      rcv_cnt[i]  = 0;
    end

    repeat (2) @(negedge clk);
    check_mask("req_avail_in", req_avail_in, '0);
    @(posedge rst_n);
    repeat (2) @(negedge clk);
    check_mask("req_avail_in", req_avail_in, '1);
    repeat (10) @(negedge clk); // Any output word here has no sender

    run_traffic(port_mask_t'(8'h04), words_single);
    wait_drained();

    run_traffic('1, words_all_each);
    wait_drained();

    // Consumer stalled, one port writes whenever its flag allows
    req_avail_out = 1'b0;
    base[flow_port] = sent_cnt[flow_port];
    repeat (flow_hold_cycles) begin
      @(negedge clk);
      drive_cycle((sent_cnt[flow_port] - base[flow_port] < flow_words_max) ? flow_bit : '0);
    end
    @(negedge clk);
    req_wr_en_in = '0;
    check_mask("req_avail_in", req_avail_in & flow_bit, '0);
    req_avail_out = 1'b1;
    wait_drained();

    fork
      begin
        run_traffic('1, words_bp_each);
        traffic_done = 1'b1;
      end
      toggle_consumer();
    join
    wait_drained();
    repeat (20) @(negedge clk);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
merge_cfg_pkg.sv
req_types_pkg.sv
sync_fifo.sv
rr_arbiter.sv
req_select.sv
rd_req_arb_ctrl.sv
rd_req_merge.sv
tb_clk_gen.sv
tb_rd_req_merge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the merger testbench with Verilator, runs it and scans the log

top=tb_rd_req_merge
log=sim.log

rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal --top-module "$top" -f build.f \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/V"$top" > "$log" 2>&1 || echo "SOME TESTS FAILED" >> "$log"
cat "$log"

grep -q "SOME TESTS FAILED" "$log" && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
